// ==== src/axis_pkg.sv ====
package axis_pkg;

    // stream widths
    localparam int DEFAULT_DATA_W   = 64;
    localparam int DEFAULT_USER_W   = 4;

    // die crossings between the rx fork and the tx merge
    localparam int DEFAULT_SLR_HOPS = 2;

    // tx arbiter grant
    typedef enum logic [1:0] {
         ARB_IDLE   = 2'd0
        ,ARB_BYPASS = 2'd1
        ,ARB_APP    = 2'd2
    } arb_state_e;

endpackage

// ==== src/axis_if.sv ====
`timescale 1ns/1ps

interface axis_if import axis_pkg::*; #(
     parameter int DATA_W = DEFAULT_DATA_W
    ,parameter int USER_W = DEFAULT_USER_W
)();

    localparam int KEEP_W = DATA_W/8;

    logic   [DATA_W-1:0]    tdata;
    logic   [KEEP_W-1:0]    tkeep;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    logic   [USER_W-1:0]    tuser;

    modport src (
         output tdata
        ,output tkeep
        ,output tvalid
        ,input  tready
        ,output tlast
        ,output tuser
    );

    modport sink (
         input  tdata
        ,input  tkeep
        ,input  tvalid
        ,output tready
        ,input  tlast
        ,input  tuser
    );

endinterface

// ==== src/hull_fifo.sv ====
`timescale 1ns/1ps

module hull_fifo import axis_pkg::*; #(
     parameter int DATA_W = DEFAULT_DATA_W
    ,parameter int USER_W = DEFAULT_USER_W
)(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   wrreq
    ,input  logic                   rdreq

    ,input  logic   [DATA_W-1:0]    data_in
    ,input  logic   [DATA_W/8-1:0]  keep_in
    ,input  logic   [USER_W-1:0]    user_in
    ,input  logic                   last_in

    ,output logic                   full
    ,output logic                   empty

    ,output logic   [DATA_W-1:0]    data_out
    ,output logic   [DATA_W/8-1:0]  keep_out
    ,output logic   [USER_W-1:0]    user_out
    ,output logic                   last_out
);

    localparam int KEEP_W = DATA_W/8;
    localparam int WORD_W = DATA_W + KEEP_W + USER_W + 1;

    logic   [WORD_W-1:0]    mem [2];
    logic   [WORD_W-1:0]    head;

    // msb is the wrap bit
    logic   [1:0]           wr_ptr;
    logic   [1:0]           rd_ptr;

    logic                   do_wr;
    logic                   do_rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[1] != rd_ptr[1]) && (wr_ptr[0] == rd_ptr[0]);

    assign do_wr = wrreq & ~full;
    assign do_rd = rdreq & ~empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[0]] <= {data_in, keep_in, user_in, last_in};
        end
    end

    // show-ahead head entry
    assign head = mem[rd_ptr[0]];
    assign {data_out, keep_out, user_out, last_out} = head;

endmodule

// ==== src/rx_tap.sv ====
`timescale 1ns/1ps

module rx_tap import axis_pkg::*; #(
     parameter int DATA_W = DEFAULT_DATA_W
    ,parameter int USER_W = DEFAULT_USER_W
)(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic   [DATA_W-1:0]    s_axis_rx_tdata
    ,input  logic   [DATA_W/8-1:0]  s_axis_rx_tkeep
    ,input  logic                   s_axis_rx_tvalid
    ,output logic                   s_axis_rx_tready
    ,input  logic                   s_axis_rx_tlast
    ,input  logic   [USER_W-1:0]    s_axis_rx_tuser

    ,output logic   [DATA_W-1:0]    m_axis_rx_tdata
    ,output logic   [DATA_W/8-1:0]  m_axis_rx_tkeep
    ,output logic                   m_axis_rx_tvalid
    ,input  logic                   m_axis_rx_tready
    ,output logic                   m_axis_rx_tlast
    ,output logic   [USER_W-1:0]    m_axis_rx_tuser

    ,axis_if.src                    app_rx
);

    logic   ing_full;
    logic   ing_empty;
    logic   rx_accept;

    // both copies move together or not at all
    assign s_axis_rx_tready = m_axis_rx_tready & ~ing_full;
    assign rx_accept        = s_axis_rx_tvalid & s_axis_rx_tready;

    assign m_axis_rx_tvalid = rx_accept;
    assign m_axis_rx_tdata  = s_axis_rx_tdata;
    assign m_axis_rx_tkeep  = s_axis_rx_tkeep;
    assign m_axis_rx_tlast  = s_axis_rx_tlast;
    assign m_axis_rx_tuser  = s_axis_rx_tuser;

    // ingress hop on the app side
    hull_fifo #(
         .DATA_W    (DATA_W )
        ,.USER_W    (USER_W )
    ) ingress_fifo (
         .clk       (clk                )
        ,.arst_n    (arst_n             )
        ,.wrreq     (rx_accept          )
        ,.rdreq     (app_rx.tready      )
        ,.data_in   (s_axis_rx_tdata    )
        ,.keep_in   (s_axis_rx_tkeep    )
        ,.user_in   (s_axis_rx_tuser    )
        ,.last_in   (s_axis_rx_tlast    )
        ,.full      (ing_full           )
        ,.empty     (ing_empty          )
        ,.data_out  (app_rx.tdata       )
        ,.keep_out  (app_rx.tkeep       )
        ,.user_out  (app_rx.tuser       )
        ,.last_out  (app_rx.tlast       )
    );

    assign app_rx.tvalid = ~ing_empty;

endmodule

// ==== src/slr_crossing_chain.sv ====
`timescale 1ns/1ps

module slr_crossing_chain import axis_pkg::*; #(
     parameter int DATA_W   = DEFAULT_DATA_W
    ,parameter int USER_W   = DEFAULT_USER_W
    ,parameter int SLR_HOPS = DEFAULT_SLR_HOPS
)(
     input  logic   clk
    ,input  logic   arst_n

    ,axis_if.sink   app_rx
    ,axis_if.src    app_tx
);

    localparam int KEEP_W = DATA_W/8;
    // one buffer and one crossing per hop, the ingress buffer lives in rx_tap
    localparam int NSTAGE = 2*SLR_HOPS - 1;

    logic   [NSTAGE-1:0]    wr_req;
    logic   [NSTAGE-1:0]    rd_req;
    logic   [NSTAGE-1:0]    full;
    logic   [NSTAGE-1:0]    empty;

    logic   [DATA_W-1:0]    st_data [NSTAGE];
    logic   [KEEP_W-1:0]    st_keep [NSTAGE];
    logic   [USER_W-1:0]    st_user [NSTAGE];
    logic                   st_last [NSTAGE];

    assign app_rx.tready = ~full[0];
    assign wr_req[0]     = app_rx.tvalid & ~full[0];

    for (genvar i = 0; i < NSTAGE; i++) begin : g_stage
        if (i > 0) begin : g_link
            assign wr_req[i] = ~empty[i-1] & ~full[i];
        end

        if (i < NSTAGE-1) begin : g_pull
            assign rd_req[i] = ~full[i+1];
        end else begin : g_tail
            assign rd_req[i] = app_tx.tready;
        end

        hull_fifo #(
             .DATA_W    (DATA_W )
            ,.USER_W    (USER_W )
        ) hop_fifo (
             .clk       (clk        )
            ,.arst_n    (arst_n     )
            ,.wrreq     (wr_req[i]  )
            ,.rdreq     (rd_req[i]  )
            ,.data_in   ((i == 0) ? app_rx.tdata : st_data[(i == 0) ? 0 : i-1])
            ,.keep_in   ((i == 0) ? app_rx.tkeep : st_keep[(i == 0) ? 0 : i-1])
            ,.user_in   ((i == 0) ? app_rx.tuser : st_user[(i == 0) ? 0 : i-1])
            ,.last_in   ((i == 0) ? app_rx.tlast : st_last[(i == 0) ? 0 : i-1])
            ,.full      (full[i]    )
            ,.empty     (empty[i]   )
            ,.data_out  (st_data[i] )
            ,.keep_out  (st_keep[i] )
            ,.user_out  (st_user[i] )
            ,.last_out  (st_last[i] )
        );
    end

    // far side of the last crossing
    assign app_tx.tvalid = ~empty[NSTAGE-1];
    assign app_tx.tdata  = st_data[NSTAGE-1];
    assign app_tx.tkeep  = st_keep[NSTAGE-1];
    assign app_tx.tuser  = st_user[NSTAGE-1];
    assign app_tx.tlast  = st_last[NSTAGE-1];

endmodule

// ==== src/tx_arb_mux.sv ====
`timescale 1ns/1ps

module tx_arb_mux import axis_pkg::*; #(
     parameter int DATA_W = DEFAULT_DATA_W
    ,parameter int USER_W = DEFAULT_USER_W
)(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic   [DATA_W-1:0]    s_axis_tx_tdata
    ,input  logic   [DATA_W/8-1:0]  s_axis_tx_tkeep
    ,input  logic                   s_axis_tx_tvalid
    ,output logic                   s_axis_tx_tready
    ,input  logic                   s_axis_tx_tlast
    ,input  logic   [USER_W-1:0]    s_axis_tx_tuser

    ,axis_if.sink                   app_tx

    ,output logic   [DATA_W-1:0]    m_axis_tx_tdata
    ,output logic   [DATA_W/8-1:0]  m_axis_tx_tkeep
    ,output logic                   m_axis_tx_tvalid
    ,input  logic                   m_axis_tx_tready
    ,output logic                   m_axis_tx_tlast
    ,output logic   [USER_W-1:0]    m_axis_tx_tuser
);

    arb_state_e arb_state;
    arb_state_e arb_next;

    logic   grant_byp;
    logic   grant_app;
    logic   out_fire;

    // bypass wins when nothing is locked
    always_comb begin
        grant_byp = 1'b0;
        grant_app = 1'b0;
        case (arb_state)
            ARB_IDLE: begin
                if (s_axis_tx_tvalid) begin
                    grant_byp = 1'b1;
                end else if (app_tx.tvalid) begin
                    grant_app = 1'b1;
                end
            end
            ARB_BYPASS: grant_byp = 1'b1;
            ARB_APP:    grant_app = 1'b1;
            default: begin
                grant_byp = 1'b0;
                grant_app = 1'b0;
            end
        endcase
    end

    assign m_axis_tx_tvalid = (grant_byp & s_axis_tx_tvalid) | (grant_app & app_tx.tvalid);
    assign m_axis_tx_tdata  = grant_app ? app_tx.tdata : s_axis_tx_tdata;
    assign m_axis_tx_tkeep  = grant_app ? app_tx.tkeep : s_axis_tx_tkeep;
    assign m_axis_tx_tlast  = grant_app ? app_tx.tlast : s_axis_tx_tlast;
    assign m_axis_tx_tuser  = grant_app ? app_tx.tuser : s_axis_tx_tuser;

    assign s_axis_tx_tready = grant_byp & m_axis_tx_tready;
    assign app_tx.tready    = grant_app & m_axis_tx_tready;

    assign out_fire = m_axis_tx_tvalid & m_axis_tx_tready;

    // lock as soon as a beat is presented, release after tlast goes out
    always_comb begin
        arb_next = arb_state;
        if (out_fire && m_axis_tx_tlast) begin
            arb_next = ARB_IDLE;
        end else if (grant_byp) begin
            arb_next = ARB_BYPASS;
        end else if (grant_app) begin
            arb_next = ARB_APP;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arb_state <= ARB_IDLE;
        end else begin
            arb_state <= arb_next;
        end
    end

endmodule

// ==== src/beehive_shell.sv ====
`timescale 1ns/1ps

module beehive_shell import axis_pkg::*; #(
     parameter int DATA_W   = DEFAULT_DATA_W
    ,parameter int USER_W   = DEFAULT_USER_W
    ,parameter int SLR_HOPS = DEFAULT_SLR_HOPS
)(
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic   [DATA_W-1:0]    s_axis_rx_tdata
    ,input  logic   [DATA_W/8-1:0]  s_axis_rx_tkeep
    ,input  logic                   s_axis_rx_tvalid
    ,output logic                   s_axis_rx_tready
    ,input  logic                   s_axis_rx_tlast
    ,input  logic   [USER_W-1:0]    s_axis_rx_tuser

    ,output logic   [DATA_W-1:0]    m_axis_rx_tdata
    ,output logic   [DATA_W/8-1:0]  m_axis_rx_tkeep
    ,output logic                   m_axis_rx_tvalid
    ,input  logic                   m_axis_rx_tready
    ,output logic                   m_axis_rx_tlast
    ,output logic   [USER_W-1:0]    m_axis_rx_tuser

    ,input  logic   [DATA_W-1:0]    s_axis_tx_tdata
    ,input  logic   [DATA_W/8-1:0]  s_axis_tx_tkeep
    ,input  logic                   s_axis_tx_tvalid
    ,output logic                   s_axis_tx_tready
    ,input  logic                   s_axis_tx_tlast
    ,input  logic   [USER_W-1:0]    s_axis_tx_tuser

    ,output logic   [DATA_W-1:0]    m_axis_tx_tdata
    ,output logic   [DATA_W/8-1:0]  m_axis_tx_tkeep
    ,output logic                   m_axis_tx_tvalid
    ,input  logic                   m_axis_tx_tready
    ,output logic                   m_axis_tx_tlast
    ,output logic   [USER_W-1:0]    m_axis_tx_tuser
);

    // app path, near die side and far die side
    axis_if #(
         .DATA_W    (DATA_W )
        ,.USER_W    (USER_W )
    ) app_rx ();

    axis_if #(
         .DATA_W    (DATA_W )
        ,.USER_W    (USER_W )
    ) app_tx ();

    rx_tap #(
         .DATA_W    (DATA_W )
        ,.USER_W    (USER_W )
    ) u_rx_tap (
         .clk               (clk                )
        ,.arst_n            (arst_n             )

        ,.s_axis_rx_tdata   (s_axis_rx_tdata    )
        ,.s_axis_rx_tkeep   (s_axis_rx_tkeep    )
        ,.s_axis_rx_tvalid  (s_axis_rx_tvalid   )
        ,.s_axis_rx_tready  (s_axis_rx_tready   )
        ,.s_axis_rx_tlast   (s_axis_rx_tlast    )
        ,.s_axis_rx_tuser   (s_axis_rx_tuser    )

        ,.m_axis_rx_tdata   (m_axis_rx_tdata    )
        ,.m_axis_rx_tkeep   (m_axis_rx_tkeep    )
        ,.m_axis_rx_tvalid  (m_axis_rx_tvalid   )
        ,.m_axis_rx_tready  (m_axis_rx_tready   )
        ,.m_axis_rx_tlast   (m_axis_rx_tlast    )
        ,.m_axis_rx_tuser   (m_axis_rx_tuser    )

        ,.app_rx            (app_rx.src         )
    );

    // app loopback across the dies
    slr_crossing_chain #(
         .DATA_W    (DATA_W     )
        ,.USER_W    (USER_W     )
        ,.SLR_HOPS  (SLR_HOPS   )
    ) u_slr_crossing_chain (
         .clk       (clk            )
        ,.arst_n    (arst_n         )
        ,.app_rx    (app_rx.sink    )
        ,.app_tx    (app_tx.src     )
    );

    tx_arb_mux #(
         .DATA_W    (DATA_W )
        ,.USER_W    (USER_W )
    ) u_tx_arb_mux (
         .clk               (clk                )
        ,.arst_n            (arst_n             )

        ,.s_axis_tx_tdata   (s_axis_tx_tdata    )
        ,.s_axis_tx_tkeep   (s_axis_tx_tkeep    )
        ,.s_axis_tx_tvalid  (s_axis_tx_tvalid   )
        ,.s_axis_tx_tready  (s_axis_tx_tready   )
        ,.s_axis_tx_tlast   (s_axis_tx_tlast    )
        ,.s_axis_tx_tuser   (s_axis_tx_tuser    )

        ,.app_tx            (app_tx.sink        )

        ,.m_axis_tx_tdata   (m_axis_tx_tdata    )
        ,.m_axis_tx_tkeep   (m_axis_tx_tkeep    )
        ,.m_axis_tx_tvalid  (m_axis_tx_tvalid   )
        ,.m_axis_tx_tready  (m_axis_tx_tready   )
        ,.m_axis_tx_tlast   (m_axis_tx_tlast    )
        ,.m_axis_tx_tuser   (m_axis_tx_tuser    )
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
     parameter real PERIOD_NS    = 100.0
    ,parameter int  RESET_CYCLES = 8
)(
     output logic   clk
    ,output logic   arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS/2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from both clock edges
        #(PERIOD_NS/4.0);
        arst_n = 1'b1;
    end

endmodule

// ==== test/tb_beehive_shell.sv ====
`timescale 1ns/1ps

module tb_beehive_shell
    import axis_pkg::*;
();

    localparam int  DATA_W       = DEFAULT_DATA_W;
    localparam int  USER_W       = DEFAULT_USER_W;
    localparam int  KEEP_W       = DATA_W/8;
    localparam real CLK_PERIOD   = 100.0;
    localparam int  RX_CYCLES    = 300;
    localparam int  MIX_CYCLES   = 600;
    localparam int  DRAIN_CYCLES = 100;
    localparam real WATCHDOG_NS  = 4.0 * (8 + RX_CYCLES + MIX_CYCLES + DRAIN_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic [USER_W-1:0] user;
        logic              last;
    } beat_t;

    logic clk;
    logic arst_n;
    logic [DATA_W-1:0] s_axis_rx_tdata, m_axis_rx_tdata, s_axis_tx_tdata, m_axis_tx_tdata;
    logic [KEEP_W-1:0] s_axis_rx_tkeep, m_axis_rx_tkeep, s_axis_tx_tkeep, m_axis_tx_tkeep;
    logic [USER_W-1:0] s_axis_rx_tuser, m_axis_rx_tuser, s_axis_tx_tuser, m_axis_tx_tuser;
    logic s_axis_rx_tvalid, m_axis_rx_tvalid, s_axis_tx_tvalid, m_axis_tx_tvalid;
    logic s_axis_rx_tready, m_axis_rx_tready, s_axis_tx_tready, m_axis_tx_tready;
    logic s_axis_rx_tlast, m_axis_rx_tlast, s_axis_tx_tlast, m_axis_tx_tlast;

    logic [31:0] lfsr_state = 32'd76975;
    beat_t       rx_exp[$];
    beat_t       byp_exp[$];
    int          rx_left = 0;
    int          tx_left = 0;
    bit          rx_fired = 1'b0;
    bit          tx_fired = 1'b0;
    bit          frame_open = 1'b0;
    bit          frame_tag = 1'b0;
    int          cycles_out_of_reset = 0;
    int          app_beats = 0;
    int          byp_beats = 0;
    int          err_cnt = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (.clk(clk), .arst_n(arst_n));

    beehive_shell u_beehive_shell (.*);

    // galois lfsr stepped once per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic bit three_in_four();
        return take_bits(2) != '0;
    endfunction

    function automatic bit coin_flip();
        return take_bits(1) != '0;
    endfunction

    // tag lives in the top user bit
    function automatic beat_t make_beat(input bit tag, input bit last);
        beat_t       b;
        logic [63:0] r;
        r = take_bits(DATA_W);
        b.data = r[DATA_W-1:0];
        r = take_bits(KEEP_W + USER_W - 1);
        b.keep = r[KEEP_W-1:0];
        b.user = {tag, r[KEEP_W +: USER_W-1]};
        b.last = last;
        return b;
    endfunction

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_eq(input string sig, input logic [63:0] got, input logic [63:0] want);
        assert (got == want)
        else flag_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", sig, got, want));
    endtask

    // phase 0 rx only, 1 both sources, 2 finish open frames
    task automatic drive_cycle(input int phase);
        beat_t b;
        if (!s_axis_rx_tvalid || rx_fired) begin
            if (phase != 2 && rx_left == 0) begin
                rx_left = int'(take_bits(2)) + 1;
            end
            if (rx_left != 0 && (phase == 2 || three_in_four())) begin
                b = make_beat(1'b1, rx_left == 1);
                rx_left--;
                s_axis_rx_tvalid <= 1'b1;
                {s_axis_rx_tdata, s_axis_rx_tkeep, s_axis_rx_tuser, s_axis_rx_tlast} <= b;
            end else begin
                s_axis_rx_tvalid <= 1'b0;
            end
        end
        if (!s_axis_tx_tvalid || tx_fired) begin
            if (phase == 1 && tx_left == 0) begin
                tx_left = int'(take_bits(2)) + 1;
            end
            if (tx_left != 0 && (phase == 2 || three_in_four())) begin
                b = make_beat(1'b0, tx_left == 1);
                tx_left--;
                s_axis_tx_tvalid <= 1'b1;
                {s_axis_tx_tdata, s_axis_tx_tkeep, s_axis_tx_tuser, s_axis_tx_tlast} <= b;
            end else begin
                s_axis_tx_tvalid <= 1'b0;
            end
        end
        m_axis_rx_tready <= (phase == 2) || three_in_four();
        m_axis_tx_tready <= (phase != 1) || coin_flip();
    endtask

    always @(negedge clk) begin : monitor
        beat_t got;
        beat_t want;
        rx_fired = s_axis_rx_tvalid && s_axis_rx_tready;
        tx_fired = s_axis_tx_tvalid && s_axis_tx_tready;
        if (!arst_n || cycles_out_of_reset == 0) begin
            expect_eq("m_axis_rx_tvalid", 64'(m_axis_rx_tvalid), 64'd0);
            expect_eq("m_axis_tx_tvalid", 64'(m_axis_tx_tvalid), 64'd0);
        end
        if (arst_n) begin
            cycles_out_of_reset++;
            expect_eq("m_axis_rx_tvalid", 64'(m_axis_rx_tvalid), 64'(rx_fired));
            assert (!s_axis_rx_tready || m_axis_rx_tready)
            else flag_error("s_axis_rx_tready was high while m_axis_rx_tready was low");
            if (m_axis_rx_tvalid) begin
                expect_eq("m_axis_rx_tdata", 64'(m_axis_rx_tdata), 64'(s_axis_rx_tdata));
                expect_eq("m_axis_rx_tkeep", 64'(m_axis_rx_tkeep), 64'(s_axis_rx_tkeep));
                expect_eq("m_axis_rx_tuser", 64'(m_axis_rx_tuser), 64'(s_axis_rx_tuser));
                expect_eq("m_axis_rx_tlast", 64'(m_axis_rx_tlast), 64'(s_axis_rx_tlast));
            end
            if (rx_fired) begin
                got = {s_axis_rx_tdata, s_axis_rx_tkeep, s_axis_rx_tuser, s_axis_rx_tlast};
                rx_exp.push_back(got);
            end
            if (tx_fired) begin
                got = {s_axis_tx_tdata, s_axis_tx_tkeep, s_axis_tx_tuser, s_axis_tx_tlast};
                byp_exp.push_back(got);
            end
            if (m_axis_tx_tvalid && m_axis_tx_tready) begin
                got = {m_axis_tx_tdata, m_axis_tx_tkeep, m_axis_tx_tuser, m_axis_tx_tlast};
                // no source switch inside a frame
                if (frame_open) begin
                    expect_eq("m_axis_tx_tuser[3]", 64'(got.user[USER_W-1]), 64'(frame_tag));
                end
                frame_open = !got.last;
                frame_tag = got.user[USER_W-1];
                if (got.user[USER_W-1]) begin
                    assert (rx_exp.size() != 0)
                    else flag_error("an app beat left m_axis_tx with no receive beat pending");
                    want = rx_exp.pop_front();
                    app_beats++;
                end else begin
                    assert (byp_exp.size() != 0)
                    else flag_error("a bypass beat left m_axis_tx that was never sent in");
                    want = byp_exp.pop_front();
                    byp_beats++;
                end
                expect_eq("m_axis_tx_tdata", 64'(got.data), 64'(want.data));
                expect_eq("m_axis_tx_tkeep", 64'(got.keep), 64'(want.keep));
                expect_eq("m_axis_tx_tuser", 64'(got.user), 64'(want.user));
                expect_eq("m_axis_tx_tlast", 64'(got.last), 64'(want.last));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the test did not finish within %0.0f ns", WATCHDOG_NS);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        s_axis_rx_tvalid <= 1'b0;
        s_axis_rx_tdata  <= '0;
        s_axis_rx_tkeep  <= '0;
        s_axis_rx_tuser  <= '0;
        s_axis_rx_tlast  <= 1'b0;
        m_axis_rx_tready <= 1'b0;
        s_axis_tx_tvalid <= 1'b0;
        s_axis_tx_tdata  <= '0;
        s_axis_tx_tkeep  <= '0;
        s_axis_tx_tuser  <= '0;
        s_axis_tx_tlast  <= 1'b0;
        m_axis_tx_tready <= 1'b0;
        wait (arst_n);
        @(posedge clk);
        repeat (RX_CYCLES) begin
            @(posedge clk);
            drive_cycle(0);
        end
        repeat (MIX_CYCLES) begin
            @(posedge clk);
            drive_cycle(1);
        end
        // let open frames finish, then wait for the app path to empty
        do begin
            @(posedge clk);
            drive_cycle(2);
            @(negedge clk);
        end while (rx_left != 0 || tx_left != 0 || s_axis_rx_tvalid || s_axis_tx_tvalid);
        @(posedge clk);
        for (int i = 0; i < DRAIN_CYCLES && (rx_exp.size() != 0 || byp_exp.size() != 0); i++) begin
            @(posedge clk);
        end
        assert (rx_exp.size() == 0)
        else flag_error($sformatf("%0d receive beats never came back on m_axis_tx", rx_exp.size()));
        assert (byp_exp.size() == 0)
        else flag_error($sformatf("%0d bypass beats never left on m_axis_tx", byp_exp.size()));
        assert (app_beats > 0 && byp_beats > 0)
        else flag_error("one of the two transmit sources never reached m_axis_tx");
        if (err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors were recorded");
        end
    end

endmodule

// ==== filelist.f ====
src/axis_pkg.sv
src/axis_if.sv
src/hull_fifo.sv
src/rx_tap.sv
src/slr_crossing_chain.sv
src/tx_arb_mux.sv
src/beehive_shell.sv
test/tb_clock.sv
test/tb_beehive_shell.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_beehive_shell -f filelist.f -o sim_tb

# $fatal gives a nonzero exit, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
